// File: Makefile
# Verilator simulation of the servo manager
TOP := servo_manager_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: common/servo_ctrl_if.sv
interface servo_ctrl_if;

    logic clear_timers;
    logic count_flicker;
    logic count_lid;
    logic count_base;
    logic spin_flicker;
    logic shift_lid;
    logic write_base;

    // Settle timer terminal counts
    logic end_flicker;
    logic end_lid;
    logic end_base;

    modport ctrl (
        output clear_timers, count_flicker, count_lid, count_base,
        output spin_flicker, shift_lid, write_base,
        input  end_flicker, end_lid, end_base
    );

    modport datapath (
        input  clear_timers, count_flicker, count_lid, count_base,
        input  spin_flicker, shift_lid, write_base,
        output end_flicker, end_lid, end_base
    );

endinterface

// File: common/servo_pkg.sv
package servo_pkg;

    // Control unit states
    typedef enum logic [2:0] {
        st_idle         = 3'd0,
        st_spin_flicker = 3'd1,
        st_shift_lid    = 3'd2,
        st_load_base    = 3'd3,
        st_wait_lid     = 3'd4,
        st_wait_base    = 3'd5,
        st_done         = 3'd6
    } ctrl_state_e;

    localparam int POSITION_BITS = 2; // Four positions per servo

    typedef logic [POSITION_BITS-1:0] position_t;

    // Flicker arm rests at 0 and kicks at the far end
    localparam position_t FLICKER_REST = position_t'(0);
    localparam position_t FLICKER_KICK = position_t'(3);

endpackage

// File: hdl/servo_manager.sv
module servo_manager import servo_pkg::*; #(
    parameter int PWM_PERIOD    = 64,
    parameter int PULSE_MIN     = 8,
    parameter int PULSE_STEP    = 8,
    parameter int SETTLE_CYCLES = 40
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          move_flicker,
    input  logic                          move_lid,
    input  logic                          move_base,
    input  position_t                     base_target,
    output logic                          pwm_flicker,
    output logic                          pwm_lid,
    output logic                          pwm_base,
    output logic                          ready,
    output logic [$bits(ctrl_state_e)-1:0] state_debug,
    output position_t                     lid_position,
    output position_t                     base_position
);

    localparam int WIDTH_BITS = $clog2(PWM_PERIOD); // All widths fit below one frame

    logic [WIDTH_BITS-1:0] width_flicker;
    logic [WIDTH_BITS-1:0] width_lid;
    logic [WIDTH_BITS-1:0] width_base;

    servo_ctrl_if ctrl_bus ();

    servo_manager_ctrl u_ctrl (
        .clock        (clock),
        .reset        (reset),
        .start        (start),
        .move_flicker (move_flicker),
        .move_lid     (move_lid),
        .move_base    (move_base),
        .ctrl         (ctrl_bus.ctrl),
        .ready        (ready),
        .state_debug  (state_debug)
    );

    servo_manager_datapath #(
        .SETTLE_CYCLES (SETTLE_CYCLES),
        .PULSE_MIN     (PULSE_MIN),
        .PULSE_STEP    (PULSE_STEP),
        .WIDTH_BITS    (WIDTH_BITS)
    ) u_datapath (
        .clock         (clock),
        .reset         (reset),
        .ctrl          (ctrl_bus.datapath),
        .base_target   (base_target),
        .width_flicker (width_flicker),
        .width_lid     (width_lid),
        .width_base    (width_base),
        .lid_position  (lid_position),
        .base_position (base_position)
    );

    servo_pwm #(.PWM_PERIOD(PWM_PERIOD), .WIDTH_BITS(WIDTH_BITS)) u_pwm_flicker (
        .clock (clock),
        .reset (reset),
        .width (width_flicker),
        .pwm   (pwm_flicker)
    );

    servo_pwm #(.PWM_PERIOD(PWM_PERIOD), .WIDTH_BITS(WIDTH_BITS)) u_pwm_lid (
        .clock (clock),
        .reset (reset),
        .width (width_lid),
        .pwm   (pwm_lid)
    );

    servo_pwm #(.PWM_PERIOD(PWM_PERIOD), .WIDTH_BITS(WIDTH_BITS)) u_pwm_base (
        .clock (clock),
        .reset (reset),
        .width (width_base),
        .pwm   (pwm_base)
    );

endmodule

// File: hdl/servo_pwm.sv
module servo_pwm #(
    parameter int PWM_PERIOD = 64,
    parameter int WIDTH_BITS = $clog2(PWM_PERIOD)
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [WIDTH_BITS-1:0] width,
    output logic                  pwm
);

    logic [WIDTH_BITS-1:0] counter;
    logic [WIDTH_BITS-1:0] width_q;
    logic [WIDTH_BITS-1:0] active_width;

    // Free running frame counter
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            counter <= '0;
        end else if (counter == WIDTH_BITS'(PWM_PERIOD - 1)) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (counter == '0) begin
            width_q <= width; // Hold width for the rest of the frame
        end
    end

    // Counter zero uses the incoming width directly
    assign active_width = (counter == '0) ? width : width_q;
    assign pwm          = (counter < active_width);

    a_width_in_frame: assert property (@(posedge clock) disable iff (reset)
        int'(active_width) < PWM_PERIOD);

endmodule

// File: project.f
common/servo_pkg.sv
common/servo_ctrl_if.sv
hdl/servo_pwm.sv
servo_manager/servo_manager_ctrl.sv
servo_manager/servo_manager_datapath.sv
hdl/servo_manager.sv
testbench/servo_manager_tb.sv

// File: servo_manager/servo_manager_ctrl.sv
module servo_manager_ctrl import servo_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         start,
    input  logic         move_flicker,
    input  logic         move_lid,
    input  logic         move_base,
    servo_ctrl_if.ctrl   ctrl,
    output logic         ready,
    output ctrl_state_e  state_debug
);

    ctrl_state_e state, state_next;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Flicker wins over lid, lid over base
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start && move_flicker)
                    state_next = st_spin_flicker;
                else if (start && move_lid)
                    state_next = st_shift_lid;
                else if (start && move_base)
                    state_next = st_load_base;
            end
            st_spin_flicker: if (ctrl.end_flicker) state_next = st_done;
            st_shift_lid:    state_next = st_wait_lid;
            st_load_base:    state_next = st_wait_base;
            st_wait_lid:     if (ctrl.end_lid) state_next = st_done;
            st_wait_base:    if (ctrl.end_base) state_next = st_done;
            st_done:         state_next = st_idle;
            default:         state_next = st_idle;
        endcase
    end

    // Moore outputs
    always_comb begin
        ctrl.clear_timers  = (state == st_idle);
        ctrl.count_flicker = (state == st_spin_flicker);
        ctrl.count_lid     = (state == st_wait_lid);
        ctrl.count_base    = (state == st_wait_base);
        ctrl.spin_flicker  = (state == st_spin_flicker); // Arm held at kick while counting
        ctrl.shift_lid     = (state == st_shift_lid);
        ctrl.write_base    = (state == st_load_base);
        ready              = (state == st_done);
    end

    assign state_debug = state;

    a_ready_single: assert property (@(posedge clock) disable iff (reset)
        ready |=> !ready);

    a_state_legal: assert property (@(posedge clock) disable iff (reset)
        state inside {st_idle, st_spin_flicker, st_shift_lid, st_load_base,
                      st_wait_lid, st_wait_base, st_done});

    a_one_update: assert property (@(posedge clock) disable iff (reset)
        $onehot0({ctrl.shift_lid, ctrl.write_base}));

endmodule

// File: servo_manager/servo_manager_datapath.sv
module servo_manager_datapath import servo_pkg::*; #(
    parameter int SETTLE_CYCLES = 40,
    parameter int PULSE_MIN     = 8,
    parameter int PULSE_STEP    = 8,
    parameter int WIDTH_BITS    = 6
) (
    input  logic                  clock,
    input  logic                  reset,
    servo_ctrl_if.datapath        ctrl,
    input  position_t             base_target,
    output logic [WIDTH_BITS-1:0] width_flicker,
    output logic [WIDTH_BITS-1:0] width_lid,
    output logic [WIDTH_BITS-1:0] width_base,
    output position_t             lid_position,
    output position_t             base_position
);

    localparam int TIMER_BITS = $clog2(SETTLE_CYCLES + 1);

    logic [2:0] count_vec;
    logic [2:0] end_vec;

    // Index 0 flicker, 1 lid, 2 base
    assign count_vec = {ctrl.count_base, ctrl.count_lid, ctrl.count_flicker};

    for (genvar i = 0; i < 3; i++) begin : g_timer
        logic [TIMER_BITS-1:0] timer;

        always_ff @(posedge clock or posedge reset) begin
            if (reset) begin
                timer <= '0;
            end else if (ctrl.clear_timers) begin
                timer <= '0;
            end else if (count_vec[i]) begin
                timer <= end_vec[i] ? '0 : timer + 1'b1; // Wrap at terminal count
            end
        end

        assign end_vec[i] = count_vec[i] && (timer == TIMER_BITS'(SETTLE_CYCLES - 1));

        a_end_needs_count: assert property (@(posedge clock) disable iff (reset)
            end_vec[i] |-> count_vec[i]);
    end

    assign ctrl.end_flicker = end_vec[0];
    assign ctrl.end_lid     = end_vec[1];
    assign ctrl.end_base    = end_vec[2];

    // Lid steps through its four positions and wraps
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lid_position <= '0;
        end else if (ctrl.shift_lid) begin
            lid_position <= lid_position + 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            base_position <= '0;
        end else if (ctrl.write_base) begin
            base_position <= base_target;
        end
    end

    function automatic logic [WIDTH_BITS-1:0] pulse_width(input position_t pos);
        return WIDTH_BITS'(PULSE_MIN + int'(pos) * PULSE_STEP);
    endfunction

    assign width_flicker = pulse_width(ctrl.spin_flicker ? FLICKER_KICK : FLICKER_REST);
    assign width_lid     = pulse_width(lid_position);
    assign width_base    = pulse_width(base_position);

endmodule

// File: testbench/servo_manager_cases.txt
// kind target expected_lid expected_base random_target
// kind 0 none, 1 flicker, 2 lid, 3 base, 4 lid with start while busy, 5 all requests
1 0 0 0 0
2 0 1 0 0
3 2 1 2 0
2 0 2 2 0
0 3 2 2 0
2 0 3 2 0
2 0 0 2 0
3 3 0 3 0
5 1 0 3 0
4 1 1 3 0
3 0 1 0 1
3 1 1 1 0
2 0 2 1 0
3 0 2 0 0
3 2 2 0 1
3 1 2 1 0
0 0 2 1 0
4 2 3 1 0
1 0 3 1 0

// File: testbench/servo_manager_tb.sv
module servo_manager_tb import servo_pkg::*; ();

    localparam int PWM_PERIOD    = 32;
    localparam int PULSE_MIN     = 4;
    localparam int PULSE_STEP    = 6;
    localparam int SETTLE_CYCLES = 40; // Longer than a frame so a frame starts during the spin
    localparam int FIELDS        = 5;  // Kind, target, lid, base, random flag
    localparam int MAX_CASES     = 32;
    localparam int WAIT_LIMIT    = SETTLE_CYCLES + 10;

    typedef enum int {
        cmd_none    = 0,
        cmd_flicker = 1,
        cmd_lid     = 2,
        cmd_base    = 3,
        cmd_busy    = 4, // Lid move with a base start during the wait
        cmd_all     = 5
    } cmd_kind_e;

    logic       clock, reset, start;
    logic       move_flicker, move_lid, move_base;
    position_t  base_target, lid_position, base_position;
    logic       pwm_flicker, pwm_lid, pwm_base, ready;
    logic [2:0] state_debug;

    logic [3:0] case_mem [MAX_CASES*FIELDS];
    int num_cases;
    int checks;
    int errors;
    int cycle_count;
    int cycle_limit;

    servo_manager #(
        .PWM_PERIOD    (PWM_PERIOD),
        .PULSE_MIN     (PULSE_MIN),
        .PULSE_STEP    (PULSE_STEP),
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) dut0 (.*);

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic int expected_width(input position_t pos);
        return PULSE_MIN + int'(pos) * PULSE_STEP;
    endfunction

    task automatic check_value(input string name, input int actual, input int expected,
                               input int case_id);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("** Error: case %0d %s = 0x%0h, expected 0x%0h",
                     case_id, name, actual, expected);
        end
    endtask

    task automatic check_true(input logic cond, input string what, input int case_id);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Case %0d failed: %s", case_id, what);
        end
    endtask

    // All three counters share one phase, so the lid edge marks the frame for every servo
    task automatic measure_frame(output int w_flicker, output int w_lid, output int w_base,
                                 output logic found);
        logic prev;
        int   n;
        prev      = pwm_lid;
        found     = 1'b0;
        w_flicker = 0;
        w_lid     = 0;
        w_base    = 0;
        n         = 0;
        while (!found && n < 2 * PWM_PERIOD) begin
            @(posedge clock);
            found = !prev && pwm_lid;
            prev  = pwm_lid;
            n++;
        end
        for (int i = 0; i < PWM_PERIOD && found; i++) begin
            if (i > 0) begin
                @(posedge clock);
            end
            w_flicker += int'(pwm_flicker);
            w_lid     += int'(pwm_lid);
            w_base    += int'(pwm_base);
        end
    endtask

    task automatic wait_ready(output int latency);
        latency = -1;
        for (int k = 1; k <= WAIT_LIMIT && latency < 0; k++) begin
            @(posedge clock);
            if (ready) begin
                latency = k;
            end
        end
    endtask

    task automatic issue_command(input cmd_kind_e kind, input position_t target);
        @(posedge clock);
        start        <= 1'b1;
        move_flicker <= (kind == cmd_flicker) || (kind == cmd_all);
        move_lid     <= (kind == cmd_lid) || (kind == cmd_busy) || (kind == cmd_all);
        move_base    <= (kind == cmd_base) || (kind == cmd_all);
        base_target  <= target;
        @(posedge clock); // Request sampled in idle here
        start        <= 1'b0;
        move_flicker <= 1'b0;
        move_lid     <= 1'b0;
        move_base    <= 1'b0;
    endtask

    task automatic start_while_busy(input position_t target);
        repeat (3) @(posedge clock);
        start       <= 1'b1;
        move_base   <= 1'b1;
        base_target <= target;
        @(posedge clock);
        start       <= 1'b0;
        move_base   <= 1'b0;
    endtask

    task automatic run_case(input int idx);
        cmd_kind_e kind;
        position_t target;
        position_t exp_lid;
        position_t exp_base;
        int        latency;
        int        exp_latency;
        int        kick_flicker;
        int        kick_lid;
        int        kick_base;
        int        w_flicker;
        int        w_lid;
        int        w_base;
        logic      kick_found;
        logic      found;
        kind         = cmd_kind_e'(int'(case_mem[idx*FIELDS]));
        target       = position_t'(case_mem[idx*FIELDS+1]);
        exp_lid      = position_t'(case_mem[idx*FIELDS+2]);
        exp_base     = position_t'(case_mem[idx*FIELDS+3]);
        kick_found   = 1'b0;
        kick_flicker = 0;
        if (case_mem[idx*FIELDS+4] != 4'h0) begin
            target   = position_t'($urandom);
            exp_base = target;
        end
        exp_latency = (kind == cmd_flicker || kind == cmd_all) ? SETTLE_CYCLES + 1
                                                              : SETTLE_CYCLES + 2;
        issue_command(kind, target);
        fork
            wait_ready(latency);
            if (kind == cmd_flicker || kind == cmd_all) begin
                measure_frame(kick_flicker, kick_lid, kick_base, kick_found);
            end
            if (kind == cmd_busy) begin
                start_while_busy(target);
            end
        join
        if (kind == cmd_none) begin
            check_true(latency < 0, "ready rose without a move request", idx + 1);
            check_value("state_debug", int'(state_debug), int'(st_idle), idx + 1);
        end else begin
            check_true(latency >= 0, "ready never rose within the wait limit", idx + 1);
            check_value("ready latency", latency, exp_latency, idx + 1);
        end
        if (kind == cmd_flicker || kind == cmd_all) begin
            check_true(kick_found, "no frame started during the flicker spin", idx + 1);
            check_value("pwm_flicker kick width", kick_flicker,
                        expected_width(FLICKER_KICK), idx + 1);
        end
        check_value("lid_position", int'(lid_position), int'(exp_lid), idx + 1);
        check_value("base_position", int'(base_position), int'(exp_base), idx + 1);
        measure_frame(w_flicker, w_lid, w_base, found);
        check_true(found, "no frame boundary seen on pwm_lid", idx + 1);
        check_value("pwm_flicker width", w_flicker, expected_width(FLICKER_REST), idx + 1);
        check_value("pwm_lid width", w_lid, expected_width(exp_lid), idx + 1);
        check_value("pwm_base width", w_base, expected_width(exp_base), idx + 1);
    endtask

    initial begin
        int   seed_sink;
        int   w_flicker;
        int   w_lid;
        int   w_base;
        logic found;
        clock        = 1'b0;
        reset        = 1'b1;
        start        = 1'b0;
        move_flicker = 1'b0;
        move_lid     = 1'b0;
        move_base    = 1'b0;
        base_target  = '0;
        checks       = 0;
        errors       = 0;
        cycle_count  = 0;
        seed_sink    = $urandom(32'h60bfbf10);
        for (int i = 0; i < MAX_CASES * FIELDS; i++) begin
            case_mem[i] = 4'hF; // Marks the end of the cases
        end
        $readmemh("testbench/servo_manager_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_mem[num_cases*FIELDS] != 4'hF) begin
            num_cases++;
        end
        cycle_limit = num_cases * (SETTLE_CYCLES + 3 * PWM_PERIOD) + 200;
        check_true(num_cases > 0, "no cases read from the cases file", 0);

        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        check_value("ready", int'(ready), 0, 0);
        check_value("state_debug", int'(state_debug), int'(st_idle), 0);
        check_value("lid_position", int'(lid_position), 0, 0);
        check_value("base_position", int'(base_position), 0, 0);
        measure_frame(w_flicker, w_lid, w_base, found);
        check_true(found, "no frame boundary seen on pwm_lid after reset", 0);
        check_value("pwm_flicker width", w_flicker, PULSE_MIN, 0);
        check_value("pwm_lid width", w_lid, PULSE_MIN, 0);
        check_value("pwm_base width", w_base, PULSE_MIN, 0);

        for (int c = 0; c < num_cases; c++) begin
            run_case(c);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
